// File: project.f
source/norm_data_pkg.sv
source/norm_ctrl_pkg.sv
source/beat_fifo.sv
source/lane_adder_tree.sv
source/moment_accumulator.sv
source/variance_unit.sv
source/norm_sequencer.sv
source/layer_stats_top.sv
testbench/tb_clock.sv
testbench/layer_stats_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module layer_stats_tb -f project.f -o layer_stats_sim \
    && ./obj_dir/layer_stats_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// File: source/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
    parameter int LANES = 8,
    parameter int DEPTH = 8
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire logic                             wr_en,
    input  wire norm_data_pkg::lane_t [LANES-1:0] wr_data,
    input  wire logic                             rd_en,
    output norm_data_pkg::lane_t [LANES-1:0]      rd_data
);
    import norm_data_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    lane_t [LANES-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        // read data shows up the cycle after rd_en
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: source/lane_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

module lane_adder_tree #(
    parameter int LANES     = 8,
    parameter int IN_WIDTH  = 8,
    parameter int OUT_WIDTH = 24
) (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire logic                           in_vld,
    input  wire logic [LANES-1:0][IN_WIDTH-1:0] in_lanes,
    output logic [OUT_WIDTH-1:0]                sum,
    output logic                                sum_vld
);

    // one register level per halving, LANES >= 2
    localparam int LEVELS = $clog2(LANES);

    logic signed [OUT_WIDTH-1:0] ext [LANES];
    logic signed [OUT_WIDTH-1:0] node [LEVELS][LANES/2];
    logic [LEVELS-1:0]           vld;

    for (genvar i = 0; i < LANES; i++) begin : g_ext
        assign ext[i] = OUT_WIDTH'(signed'(in_lanes[i]));
    end

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar n = 0; n < (LANES >> (l + 1)); n++) begin : g_node
            if (l == 0) begin : g_leaf
                always_ff @(posedge clk) begin
                    node[0][n] <= ext[2*n] + ext[2*n+1];
                end
            end else begin : g_inner
                always_ff @(posedge clk) begin
                    node[l][n] <= node[l-1][2*n] + node[l-1][2*n+1];
                end
            end
        end
    end

    // valid travels next to the data, one bit per level
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld <= '0;
        end else begin
            vld <= LEVELS'({vld, in_vld});
        end
    end

    assign sum     = node[LEVELS-1][0];
    assign sum_vld = vld[LEVELS-1];

endmodule

`default_nettype wire

// File: source/layer_stats_top.sv
`timescale 1ns/1ps
`default_nettype none

module layer_stats_top #(
    parameter int LANES = 8,
    parameter int DEPTH = 8
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire norm_ctrl_pkg::norm_cfg_t         cfg,
    input  wire logic                             cfg_vld,
    input  wire norm_data_pkg::lane_t [LANES-1:0] in_data,
    input  wire logic                             in_data_vld,
    output norm_data_pkg::norm_stats_t            stats,
    output logic                                  stats_vld,
    output norm_data_pkg::lane_t [LANES-1:0]      out_data,
    output logic                                  out_data_vld,
    output logic                                  out_data_last
);
    import norm_data_pkg::*;
    import norm_ctrl_pkg::*;

    lane_t [LANES-1:0] beat;
    logic              beat_vld;
    logic              beat_last;
    elem_count_t       elem_count;
    shift_t            shift;
    logic              fifo_wr_en;
    lane_t [LANES-1:0] fifo_wr_data;
    logic              fifo_rd_en;
    lane_t [LANES-1:0] fifo_rd_data;
    moment_sums_t      sums;
    logic              sums_vld;

    norm_sequencer #(
        .LANES(LANES),
        .DEPTH(DEPTH)
    ) norm_sequencer_i (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .cfg_vld      (cfg_vld),
        .in_data      (in_data),
        .in_data_vld  (in_data_vld),
        .stats        (stats),
        .stats_vld    (stats_vld),
        .beat         (beat),
        .beat_vld     (beat_vld),
        .beat_last    (beat_last),
        .elem_count   (elem_count),
        .shift        (shift),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .out_data     (out_data),
        .out_data_vld (out_data_vld),
        .out_data_last(out_data_last)
    );

    beat_fifo #(
        .LANES(LANES),
        .DEPTH(DEPTH)
    ) beat_fifo_i (
        .clk    (clk),
        .rstn   (rstn),
        .wr_en  (fifo_wr_en),
        .wr_data(fifo_wr_data),
        .rd_en  (fifo_rd_en),
        .rd_data(fifo_rd_data)
    );

    moment_accumulator #(
        .LANES(LANES)
    ) moment_accumulator_i (
        .clk      (clk),
        .rstn     (rstn),
        .beat     (beat),
        .beat_vld (beat_vld),
        .beat_last(beat_last),
        .sums     (sums),
        .sums_vld (sums_vld)
    );

    variance_unit variance_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .sums      (sums),
        .sums_vld  (sums_vld),
        .elem_count(elem_count),
        .shift     (shift),
        .stats     (stats),
        .stats_vld (stats_vld)
    );

endmodule

`default_nettype wire

// File: source/moment_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module moment_accumulator #(
    parameter int LANES = 8
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire norm_data_pkg::lane_t [LANES-1:0] beat,
    input  wire logic                             beat_vld,
    input  wire logic                             beat_last,
    output norm_data_pkg::moment_sums_t           sums,
    output logic                                  sums_vld
);
    import norm_data_pkg::*;

    localparam int LEVELS = $clog2(LANES);

    lane_t [LANES-1:0] beat_q;
    sqr_t [LANES-1:0]  sqr_q;
    logic              beat_q_vld;
    logic              beat_q_last;
    logic [LEVELS-1:0] last_pipe;
    sum_t              tree_sum;
    sqr_sum_t          tree_sqr_sum;
    logic              tree_sum_vld;
    logic              tree_sqr_vld;
    sum_t              acc_sum;
    sqr_sum_t          acc_sqr_sum;
    logic              tree_last;

    always_ff @(posedge clk) begin
        if (beat_vld) begin
            beat_q <= beat;
            for (int i = 0; i < LANES; i++) begin
                sqr_q[i] <= sqr_t'(beat[i] * beat[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_q_vld  <= 1'b0;
            beat_q_last <= 1'b0;
            last_pipe   <= '0;
        end else begin
            beat_q_vld  <= beat_vld;
            beat_q_last <= beat_last;
            // last tag follows the tree latency
            last_pipe   <= LEVELS'({last_pipe, beat_q_vld && beat_q_last});
        end
    end

    lane_adder_tree #(
        .LANES    (LANES),
        .IN_WIDTH ($bits(lane_t)),
        .OUT_WIDTH($bits(sum_t))
    ) sum_tree_i (
        .clk     (clk),
        .rstn    (rstn),
        .in_vld  (beat_q_vld),
        .in_lanes(beat_q),
        .sum     (tree_sum),
        .sum_vld (tree_sum_vld)
    );

    // squares are never negative, so sign extension is harmless
    lane_adder_tree #(
        .LANES    (LANES),
        .IN_WIDTH ($bits(sqr_t)),
        .OUT_WIDTH($bits(sqr_sum_t))
    ) sqr_tree_i (
        .clk     (clk),
        .rstn    (rstn),
        .in_vld  (beat_q_vld),
        .in_lanes(sqr_q),
        .sum     (tree_sqr_sum),
        .sum_vld (tree_sqr_vld)
    );

    assign tree_last = last_pipe[LEVELS-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_sum     <= '0;
            acc_sqr_sum <= '0;
            sums_vld    <= 1'b0;
        end else begin
            sums_vld <= tree_sum_vld && tree_last;
            if (tree_sum_vld) begin
                acc_sum <= tree_last ? '0 : acc_sum + tree_sum;
            end
            if (tree_sqr_vld) begin
                acc_sqr_sum <= tree_last ? '0 : acc_sqr_sum + tree_sqr_sum;
            end
        end
    end

    // totals include the final beat
    always_ff @(posedge clk) begin
        if (tree_sum_vld && tree_last) begin
            sums.sum     <= acc_sum + tree_sum;
            sums.sqr_sum <= acc_sqr_sum + tree_sqr_sum;
        end
    end

endmodule

`default_nettype wire

// File: source/norm_ctrl_pkg.sv
`default_nettype none

package norm_ctrl_pkg;

    localparam int COUNT_W = 10;
    localparam int SHIFT_W = 4;

    typedef logic [COUNT_W-1:0] elem_count_t;
    typedef logic [SHIFT_W-1:0] shift_t;

    // captured with a single strobe while idle
    typedef struct packed {
        elem_count_t elem_count;
        shift_t      shift;
    } norm_cfg_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COMPUTE,
        REPLAY
    } norm_state_e;

endpackage

`default_nettype wire

// File: source/norm_data_pkg.sv
`default_nettype none

package norm_data_pkg;

    // element widths of the datapath
    localparam int LANE_W    = 8;
    localparam int SQR_W     = 16;
    localparam int SUM_W     = 24;
    localparam int SQR_SUM_W = 32;

    typedef logic signed [LANE_W-1:0]    lane_t;
    typedef logic        [SQR_W-1:0]     sqr_t;
    typedef logic signed [SUM_W-1:0]     sum_t;
    typedef logic        [SQR_SUM_W-1:0] sqr_sum_t;
    typedef logic signed [LANE_W-1:0]    mean_t;
    typedef logic signed [SQR_W-1:0]     var_t;

    // totals of one vector, sum in the upper bits
    typedef struct packed {
        sum_t     sum;
        sqr_sum_t sqr_sum;
    } moment_sums_t;

    typedef struct packed {
        mean_t mean;
        var_t  variance;
    } norm_stats_t;

endpackage

`default_nettype wire

// File: source/norm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module norm_sequencer #(
    parameter int LANES = 8,
    parameter int DEPTH = 8
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire norm_ctrl_pkg::norm_cfg_t         cfg,
    input  wire logic                             cfg_vld,
    input  wire norm_data_pkg::lane_t [LANES-1:0] in_data,
    input  wire logic                             in_data_vld,
    input  wire norm_data_pkg::norm_stats_t       stats,
    input  wire logic                             stats_vld,
    output norm_data_pkg::lane_t [LANES-1:0]      beat,
    output logic                                  beat_vld,
    output logic                                  beat_last,
    output norm_ctrl_pkg::elem_count_t            elem_count,
    output norm_ctrl_pkg::shift_t                 shift,
    output logic                                  fifo_wr_en,
    output norm_data_pkg::lane_t [LANES-1:0]      fifo_wr_data,
    output logic                                  fifo_rd_en,
    input  wire norm_data_pkg::lane_t [LANES-1:0] fifo_rd_data,
    output norm_data_pkg::lane_t [LANES-1:0]      out_data,
    output logic                                  out_data_vld,
    output logic                                  out_data_last
);
    import norm_data_pkg::*;
    import norm_ctrl_pkg::*;

    localparam int LANE_BITS = $clog2(LANES);
    localparam int CNT_W     = $clog2(DEPTH + 1);

    norm_state_e       state;
    norm_cfg_t         cfg_q;
    lane_t [LANES-1:0] beat_q;
    logic [CNT_W-1:0]  beat_cnt;
    logic [CNT_W-1:0]  last_beat;

    assign elem_count = cfg_q.elem_count;
    assign shift      = cfg_q.shift;

    // index of the final beat, count is a multiple of LANES
    assign last_beat = CNT_W'((cfg_q.elem_count >> LANE_BITS) - 1'b1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            cfg_q     <= '0;
            beat_cnt  <= '0;
            beat_vld  <= 1'b0;
            beat_last <= 1'b0;
        end else begin
            beat_vld  <= 1'b0;
            beat_last <= 1'b0;
            case (state)
                IDLE: begin
                    if (cfg_vld) begin
                        cfg_q <= cfg;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_data_vld) begin
                        beat_vld  <= 1'b1;
                        beat_last <= (beat_cnt == last_beat);
                        if (beat_cnt == last_beat) begin
                            beat_cnt <= '0;
                            state    <= COMPUTE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                COMPUTE: begin
                    if (stats_vld) begin
                        state <= REPLAY;
                    end
                end
                REPLAY: begin
                    // one buffer read per cycle
                    if (beat_cnt == last_beat) begin
                        beat_cnt <= '0;
                        state    <= IDLE;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD && in_data_vld) begin
            beat_q <= in_data;
        end
    end

    // same registered beat feeds the buffer and the accumulator
    assign beat         = beat_q;
    assign fifo_wr_data = beat_q;
    assign fifo_wr_en   = beat_vld;
    assign fifo_rd_en   = (state == REPLAY);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_data_vld  <= 1'b0;
            out_data_last <= 1'b0;
        end else begin
            out_data_vld  <= fifo_rd_en;
            out_data_last <= fifo_rd_en && (beat_cnt == last_beat);
        end
    end

    // centering on the registered buffer output, wraps to 8 bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            out_data[i] = fifo_rd_data[i] - stats.mean;
        end
    end

endmodule

`default_nettype wire

// File: source/variance_unit.sv
`timescale 1ns/1ps
`default_nettype none

module variance_unit (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire norm_data_pkg::moment_sums_t sums,
    input  wire logic                        sums_vld,
    input  wire norm_ctrl_pkg::elem_count_t  elem_count,
    input  wire norm_ctrl_pkg::shift_t       shift,
    output norm_data_pkg::norm_stats_t       stats,
    output logic                             stats_vld
);
    import norm_data_pkg::*;

    mean_t mean_s1;
    sqr_t  sqr_mean_s1;
    logic  vld_s1;
    mean_t mean_s2;
    sqr_t  mean_sq_s2;
    sqr_t  sqr_shift_s2;
    logic  vld_s2;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_s1    <= 1'b0;
            vld_s2    <= 1'b0;
            stats_vld <= 1'b0;
        end else begin
            vld_s1    <= sums_vld;
            vld_s2    <= vld_s1;
            stats_vld <= vld_s2;
        end
    end

    always_ff @(posedge clk) begin
        // signed divide truncates toward zero
        if (sums_vld) begin
            mean_s1     <= mean_t'(sums.sum / sum_t'(elem_count));
            sqr_mean_s1 <= sqr_t'(sums.sqr_sum / sqr_sum_t'(elem_count));
        end
        if (vld_s1) begin
            mean_s2      <= mean_s1;
            mean_sq_s2   <= sqr_t'(mean_s1 * mean_s1);
            sqr_shift_s2 <= sqr_mean_s1 >> shift;
        end
        // results stay until the next vector
        if (vld_s2) begin
            stats.mean     <= mean_s2;
            stats.variance <= var_t'(sqr_shift_s2 - mean_sq_s2);
        end
    end

endmodule

`default_nettype wire

// File: testbench/layer_stats_tb.sv
`timescale 1ns/1ps
`default_nettype none

module layer_stats_tb;
    import norm_data_pkg::*;
    import norm_ctrl_pkg::*;

    localparam int LANES   = 8;
    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 200;

    typedef lane_t [LANES-1:0] beat_t;

    wire logic   clk;
    logic        rstn;
    norm_cfg_t   cfg;
    logic        cfg_vld;
    beat_t       in_data;
    logic        in_data_vld;
    norm_stats_t stats;
    logic        stats_vld;
    beat_t       out_data;
    logic        out_data_vld;
    logic        out_data_last;

    int    seed = 32'h6a951836;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    beat_t vec_beats [DEPTH];

    tb_clock #(.PERIOD(40)) tb_clock_i (.clk(clk));

    layer_stats_top #(
        .LANES(LANES),
        .DEPTH(DEPTH)
    ) layer_stats_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .cfg_vld      (cfg_vld),
        .in_data      (in_data),
        .in_data_vld  (in_data_vld),
        .stats        (stats),
        .stats_vld    (stats_vld),
        .out_data     (out_data),
        .out_data_vld (out_data_vld),
        .out_data_last(out_data_last)
    );

    function automatic beat_t random_beat();
        beat_t b;
        for (int i = 0; i < LANES; i++) begin
            b[i] = lane_t'($random(seed));
        end
        return b;
    endfunction

    // mean truncates toward zero while variance and centered lanes wrap
    function automatic norm_stats_t model_stats(input int beats, input shift_t sh);
        int          sum;
        int          sqr_sum;
        int          count;
        int          mean_i;
        int          sqr_mean;
        norm_stats_t s;
        sum     = 0;
        sqr_sum = 0;
        count   = beats * LANES;
        for (int b = 0; b < beats; b++) begin
            for (int l = 0; l < LANES; l++) begin
                sum     += int'(vec_beats[b][l]);
                sqr_sum += int'(vec_beats[b][l]) * int'(vec_beats[b][l]);
            end
        end
        mean_i     = sum / count;
        sqr_mean   = sqr_sum / count;
        s.mean     = mean_t'(mean_i);
        s.variance = var_t'((sqr_mean >> sh) - mean_i * mean_i);
        return s;
    endfunction

    function automatic beat_t center_beat(input beat_t b, input mean_t m);
        beat_t c;
        for (int i = 0; i < LANES; i++) begin
            c[i] = lane_t'(int'(b[i]) - int'(m));
        end
        return c;
    endfunction

    task automatic check_stats(input string name, input norm_stats_t exp, input norm_stats_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected mean %0d variance %0d, got mean %0d variance %0d",
                     name, exp.mean, exp.variance, act.mean, act.variance);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input int idx, input beat_t exp,
                              input logic exp_last, input beat_t act, input logic act_last);
        if (exp !== act || exp_last !== act_last) begin
            $display("Mismatch in %s: beat %0d expected %h last %b, got %h last %b",
                     name, idx, exp, exp_last, act, act_last);
            errors++;
        end
    endtask

    // strobes and beats that the DUT must ignore while busy
    task automatic drive_noise(input bit on);
        cfg_vld     <= on;
        in_data_vld <= on;
        if (on) begin
            cfg.elem_count <= elem_count_t'(LANES);
            cfg.shift      <= shift_t'(7);
            in_data        <= random_beat();
        end
    endtask

    task automatic run_vector(input string name, input int beats, input shift_t sh,
                              input bit gaps, input bit noise);
        norm_stats_t exp_stats;
        int          gap;
        int          cycles;
        bit          timed_out;
        exp_stats = model_stats(beats, sh);
        timed_out = 1'b0;
        @(posedge clk);
        cfg.elem_count <= elem_count_t'(beats * LANES);
        cfg.shift      <= sh;
        cfg_vld        <= 1'b1;
        for (int b = 0; b < beats; b++) begin
            gap = gaps ? int'($unsigned($random(seed)) % 4) : 0;
            repeat (gap) begin
                @(posedge clk);
                cfg_vld     <= 1'b0;
                in_data_vld <= 1'b0;
                in_data     <= random_beat();
            end
            @(posedge clk);
            cfg_vld     <= 1'b0;
            in_data_vld <= 1'b1;
            in_data     <= vec_beats[b];
        end
        cycles = 0;
        do begin
            @(posedge clk);
            drive_noise(noise);
            @(negedge clk);
            cycles++;
        end while (!stats_vld && cycles < TIMEOUT);
        if (!stats_vld) begin
            $display("%s: timed out waiting for stats_vld", name);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_stats(name, exp_stats, stats);
        end
        // noise stops before the last read so the idle state sees none of it
        // after the first beat the others follow on consecutive cycles
        for (int k = 0; k < beats && !timed_out; k++) begin
            cycles = 0;
            do begin
                @(posedge clk);
                drive_noise(noise && (k < beats - 1));
                @(negedge clk);
                cycles++;
            end while (!out_data_vld && k == 0 && cycles < TIMEOUT);
            if (!out_data_vld) begin
                if (k == 0) begin
                    $display("%s: timed out waiting for output beat %0d", name, k);
                end else begin
                    $display("%s: output beat %0d did not follow on the next cycle", name, k);
                end
                errors++;
                timed_out = 1'b1;
            end else begin
                check_beat(name, k, center_beat(vec_beats[k], exp_stats.mean),
                           (k == beats - 1), out_data, out_data_last);
            end
        end
        @(posedge clk);
        cfg_vld     <= 1'b0;
        in_data_vld <= 1'b0;
        @(negedge clk);
        if (!timed_out && out_data_vld) begin
            $display("%s: output valid still high after the last beat", name);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_idle_after_reset();
        int err_start;
        err_start = errors;
        repeat (10) begin
            @(negedge clk);
            if (stats_vld || out_data_vld || out_data_last) begin
                $display("idle_after_reset: an output valid went high with no input");
                errors++;
            end
        end
        finish_test("idle_after_reset", err_start);
    endtask

    task automatic test_single_beat();
        int err_start;
        err_start    = errors;
        vec_beats[0] = random_beat();
        run_vector("single_beat", 1, shift_t'(0), 1'b0, 1'b0);
        finish_test("single_beat", err_start);
    endtask

    task automatic test_full_depth_gaps();
        int err_start;
        err_start = errors;
        for (int b = 0; b < DEPTH; b++) begin
            vec_beats[b] = random_beat();
        end
        run_vector("full_depth_gaps", DEPTH, shift_t'(1), 1'b1, 1'b0);
        finish_test("full_depth_gaps", err_start);
    endtask

    task automatic test_extreme_lanes();
        int err_start;
        err_start = errors;
        // a single 127 among -128s pulls the mean to -112 so 127 wraps when centered
        for (int l = 0; l < LANES; l++) begin
            vec_beats[0][l] = (l == 0) ? lane_t'(127) : lane_t'(-128);
            vec_beats[1][l] = lane_t'(-128);
        end
        run_vector("extreme_lanes", 2, shift_t'(5), 1'b0, 1'b0);
        for (int b = 0; b < 4; b++) begin
            for (int l = 0; l < LANES; l++) begin
                if (b == 3 || l % 2 == 0) begin
                    vec_beats[b][l] = lane_t'(127);
                end else begin
                    vec_beats[b][l] = lane_t'(-128);
                end
            end
        end
        run_vector("extreme_lanes", 4, shift_t'(15), 1'b1, 1'b0);
        finish_test("extreme_lanes", err_start);
    endtask

    task automatic test_back_to_back();
        int err_start;
        err_start = errors;
        for (int b = 0; b < 3; b++) begin
            vec_beats[b] = random_beat();
        end
        run_vector("back_to_back", 3, shift_t'(0), 1'b1, 1'b1);
        for (int b = 0; b < 5; b++) begin
            vec_beats[b] = random_beat();
        end
        run_vector("back_to_back", 5, shift_t'(2), 1'b1, 1'b1);
        finish_test("back_to_back", err_start);
    endtask

    initial begin
        rstn        = 1'b0;
        cfg         = '0;
        cfg_vld     = 1'b0;
        in_data     = '0;
        in_data_vld = 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        test_idle_after_reset();
        test_single_beat();
        test_full_depth_gaps();
        test_extreme_lanes();
        test_back_to_back();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
